/* all.f */
common/avalonPkg.sv
common/fabricPkg.sv
logic/burstMemory.sv
interconnect/inputDecoder.sv
interconnect/slaveMux.sv
interconnect/avalonSubsystem.sv
bench/tbAvalonSubsystem.sv

/* Bender.yml */
package:
  name: avalon_subsystem

sources:
  - files:
      - common/avalonPkg.sv
      - common/fabricPkg.sv
      - logic/burstMemory.sv
      - interconnect/inputDecoder.sv
      - interconnect/slaveMux.sv
      - interconnect/avalonSubsystem.sv
  - target: test
    files:
      - bench/tbAvalonSubsystem.sv

/* bench/testinput.txt */
# op gap addr burst words; op W writes the words, op R expects them back in order.
# gap 1 puts random idle cycles before the command, gap 0 issues it back to back.
W 1 00000003 1 11110000
W 1 02000003 1 11110001
W 1 04000003 1 11110002
W 1 06000003 1 11110003
W 1 08000003 1 11110004
R 1 00000003 1 11110000
R 1 02000003 1 11110001
R 1 04000003 1 11110002
R 1 06000003 1 11110003
R 1 08000003 1 11110004
# Bursts of 4 and 8 over all wait-state settings.
W 1 02000010 4 a1000000 a1000001 a1000002 a1000003
W 1 06000020 8 b3000000 b3000001 b3000002 b3000003 b3000004 b3000005 b3000006 b3000007
W 1 04000030 4 c2000000 c2000001 c2000002 c2000003
W 1 08000008 8 d4000000 d4000001 d4000002 d4000003 d4000004 d4000005 d4000006 d4000007
W 1 00000038 8 e0000000 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007
R 1 02000010 4 a1000000 a1000001 a1000002 a1000003
R 1 06000020 8 b3000000 b3000001 b3000002 b3000003 b3000004 b3000005 b3000006 b3000007
R 1 04000030 4 c2000000 c2000001 c2000002 c2000003
R 1 08000008 8 d4000000 d4000001 d4000002 d4000003 d4000004 d4000005 d4000006 d4000007
R 1 00000038 8 e0000000 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007
R 1 06000024 2 b3000004 b3000005
# Upper bits with no matching base land in slave 0.
W 1 0a000007 1 5a5a0007
R 1 00000007 1 5a5a0007
W 1 3e000009 2 5a5a0009 5a5a000a
R 1 00000009 2 5a5a0009 5a5a000a
R 1 1400000a 1 5a5a000a
# A slave 4 write leaves the same low address in other slaves alone.
W 1 08000003 1 44440004
R 1 00000003 1 11110000
R 1 02000003 1 11110001
R 1 04000003 1 11110002
R 1 06000003 1 11110003
R 1 08000003 1 44440004
# Back to back, switching slaves between commands.
W 0 06000000 2 77770000 77770001
W 0 00000000 1 66660000
R 0 06000000 2 77770000 77770001
R 0 00000000 1 66660000
R 0 02000010 4 a1000000 a1000001 a1000002 a1000003
W 0 02000011 1 88880011
R 0 02000010 4 a1000000 88880011 a1000002 a1000003
R 0 04000032 2 c2000002 c2000003

/* bench/tbAvalonSubsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tbAvalonSubsystem import avalonPkg::*; ();

    localparam int RstCycles = 10;
    localparam int SelBits = 5;
    localparam int SlaveWaits [5] = '{0, 1, 2, 3, 1}; // Indexed by base value.

    typedef enum logic {
        OpWrite,
        OpRead
    } tbOp_e;

    logic     i_Clk;
    logic     i_arstN;
    avAddr_t  i_Addr;
    logic     i_Read;
    logic     i_Write;
    avBurst_t i_BurstCount;
    avData_t  i_WriteData;
    logic     o_WaitRequest;
    avData_t  o_ReadData;
    logic     o_ReadDataValid;

    // Command list, data words of all commands in one flat queue.
    tbOp_e    cmdOp [$];
    logic     cmdGap [$];
    avAddr_t  cmdAddr [$];
    avBurst_t cmdBurst [$];
    int       cmdBase [$];
    avData_t  cmdData [$];

    avBurst_t expectedRuns [$]; // One entry per accepted read.
    avBurst_t runLen;
    int       cycleCount;
    int       cycleLimit = 0;

    avalonSubsystem DUT (
        .i_Clk           (i_Clk),
        .i_arstN         (i_arstN),
        .i_Addr          (i_Addr),
        .i_Read          (i_Read),
        .i_Write         (i_Write),
        .i_BurstCount    (i_BurstCount),
        .i_WriteData     (i_WriteData),
        .o_WaitRequest   (o_WaitRequest),
        .o_ReadData      (o_ReadData),
        .o_ReadDataValid (o_ReadDataValid)
    );

    initial begin
        i_Clk = 1'b0;
        forever #10 i_Clk = ~i_Clk;
    end

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkData(input avData_t expected, input avData_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail o_ReadData expected %h got %h", expected, actual));
        end
    endtask

    task automatic checkWait(input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail o_WaitRequest expected %h got %h", expected, actual));
        end
    endtask

    task automatic checkValid(input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail o_ReadDataValid expected %h got %h",
                expected, actual));
        end
    endtask

    task automatic checkBeats(input avBurst_t expected, input avBurst_t actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail o_ReadDataValid beats expected %h got %h",
                expected, actual));
        end
    endtask

    // Wait states of the slave that an address decodes to.
    function automatic int waitStates(input avAddr_t addr);
        int sel;
        sel = int'(addr[AddrWidth-1 -: SelBits]);
        if (sel >= $size(SlaveWaits)) begin
            sel = 0; // No base matches, lands in slave 0.
        end
        return SlaveWaits[sel];
    endfunction

    task automatic readStimulus();
        int       fd;
        int       c;
        int       gap;
        byte      opChar;
        avAddr_t  addr;
        avBurst_t burst;
        avData_t  word;
        fd = $fopen("bench/testinput.txt", "r");
        if (fd == 0) begin
            stopOnError("Could not open the stimulus file bench/testinput.txt.");
        end
        while ($fscanf(fd, " %c", opChar) == 1) begin
            if (opChar == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (opChar == "W" || opChar == "R") begin
                if ($fscanf(fd, "%d %h %d", gap, addr, burst) != 3 || burst == '0) begin
                    stopOnError("Malformed command line in the stimulus file.");
                end
                if (opChar == "W") begin
                    cmdOp.push_back(OpWrite);
                end else begin
                    cmdOp.push_back(OpRead);
                end
                cmdGap.push_back(gap != 0);
                cmdAddr.push_back(addr);
                cmdBurst.push_back(burst);
                cmdBase.push_back(cmdData.size());
                for (int b = 0; b < burst; b++) begin
                    if ($fscanf(fd, "%h", word) != 1) begin
                        stopOnError("Stimulus file has fewer data words than the burst count.");
                    end
                    cmdData.push_back(word);
                end
            end else begin
                stopOnError($sformatf("Unknown opcode %c in the stimulus file.", opChar));
            end
        end
        $fclose(fd);
    endtask

    task automatic driveIdle();
        i_Read = 1'b0;
        i_Write = 1'b0;
        i_Addr = '0;
        i_BurstCount = '0;
        i_WriteData = '0;
    endtask

    // Expects the given stall cycles, returns on the edge that takes the command.
    task automatic waitAccept(input int stalls);
        for (int k = 0; k <= stalls; k++) begin
            @(posedge i_Clk);
            checkWait(k < stalls, o_WaitRequest);
        end
    endtask

    task automatic writeBurst(input int n);
        for (int b = 0; b < cmdBurst[n]; b++) begin
            if (b != 0) begin
                @(negedge i_Clk);
            end
            i_Write = 1'b1;
            i_Read = 1'b0;
            i_Addr = cmdAddr[n]; // Burst address stays fixed.
            i_BurstCount = cmdBurst[n];
            i_WriteData = cmdData[cmdBase[n] + b];
            waitAccept((b == 0) ? waitStates(cmdAddr[n]) : 0);
        end
    endtask

    task automatic readBurst(input int n);
        i_Read = 1'b1;
        i_Write = 1'b0;
        i_Addr = cmdAddr[n];
        i_BurstCount = cmdBurst[n];
        i_WriteData = '0;
        waitAccept(waitStates(cmdAddr[n]));
        expectedRuns.push_back(cmdBurst[n]);
        @(negedge i_Clk);
        driveIdle();
        // Beats follow the accept edge on consecutive cycles.
        for (int b = 0; b < cmdBurst[n]; b++) begin
            @(posedge i_Clk);
            checkValid(1'b1, o_ReadDataValid);
            checkData(cmdData[cmdBase[n] + b], o_ReadData);
        end
    endtask

    initial begin
        int limit;
        i_arstN = 1'b0;
        driveIdle();
        void'($urandom(32'h5dd1));
        readStimulus();
        if (cmdOp.size() == 0) begin
            stopOnError("The stimulus file holds no commands.");
        end
        limit = RstCycles;
        foreach (cmdBurst[n]) begin
            limit += (int'(cmdBurst[n]) + 4) * 8;
        end
        cycleLimit = limit;
        repeat (RstCycles) @(negedge i_Clk);
        i_arstN = 1'b1;
        for (int n = 0; n < cmdOp.size(); n++) begin
            @(negedge i_Clk);
            if (cmdGap[n]) begin
                driveIdle();
                repeat (1 + $urandom % 3) @(negedge i_Clk);
            end
            if (cmdOp[n] == OpWrite) begin
                writeBurst(n);
            end else begin
                readBurst(n);
            end
        end
        @(negedge i_Clk);
        driveIdle();
        repeat (4) @(negedge i_Clk);
        if (expectedRuns.size() != 0) begin
            stopOnError("A read burst ended without its data-valid run being counted.");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // Length of each contiguous data-valid run against its read.
    initial begin
        runLen = '0;
        forever begin
            @(posedge i_Clk);
            if (o_ReadDataValid === 1'b1) begin
                runLen++;
            end else if (runLen != '0) begin
                if (expectedRuns.size() == 0) begin
                    stopOnError("Read data arrived with no read command pending.");
                end
                checkBeats(expectedRuns.pop_front(), runLen);
                runLen = '0;
            end
        end
    end

    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        forever begin
            @(posedge i_Clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                stopOnError($sformatf("Run did not finish within %0d clock cycles.",
                    cycleLimit));
            end
        end
    end

endmodule

`default_nettype wire

/* interconnect/avalonSubsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module avalonSubsystem import avalonPkg::*, fabricPkg::*; #(
    parameter int SelBits = 5,
    parameter int SlaveBase [SlaveCount] = '{0, 1, 2, 3, 4},
    parameter int MemDepthLog2 = 6
) (
    input  wire           i_Clk,
    input  wire           i_arstN,

    input  wire avAddr_t  i_Addr,
    input  wire           i_Read,
    input  wire           i_Write,
    input  wire avBurst_t i_BurstCount,
    input  wire avData_t  i_WriteData,

    output wire           o_WaitRequest,
    output wire avData_t  o_ReadData,
    output wire           o_ReadDataValid
);

    // Wait states per slave port.
    localparam int WaitTable [SlaveCount] = '{0, 1, 2, 3, 1};

    wire slaveMask_t slaveReq;
    wire slaveMask_t slvRead;
    wire slaveMask_t slvWrite;
    wire avAddr_t    slvAddr;
    wire avBurst_t   slvBurstCount;
    wire avData_t    slvWriteData;
    wire slaveMask_t slvWaitRequest;
    wire avData_t    slvReadData [SlaveCount];
    wire slaveMask_t slvReadDataValid;

    inputDecoder #(
        .SelBits   (SelBits),
        .SlaveBase (SlaveBase)
    ) uDecoder (
        .i_Clk            (i_Clk),
        .i_arstN          (i_arstN),
        .i_Addr           (i_Addr),
        .i_Read           (i_Read),
        .i_Write          (i_Write),
        .i_BurstCount     (i_BurstCount),
        .i_WaitRequest    (o_WaitRequest),
        .i_ReadDataValid  (o_ReadDataValid),
        .o_SlaveReq       (slaveReq),
        .o_NewTransaction ()
    );

    slaveMux uMux (
        .i_SlaveReq         (slaveReq),
        .i_Addr             (i_Addr),
        .i_Read             (i_Read),
        .i_Write            (i_Write),
        .i_BurstCount       (i_BurstCount),
        .i_WriteData        (i_WriteData),
        .o_SlvRead          (slvRead),
        .o_SlvWrite         (slvWrite),
        .o_SlvAddr          (slvAddr),
        .o_SlvBurstCount    (slvBurstCount),
        .o_SlvWriteData     (slvWriteData),
        .i_SlvWaitRequest   (slvWaitRequest),
        .i_SlvReadData      (slvReadData),
        .i_SlvReadDataValid (slvReadDataValid),
        .o_WaitRequest      (o_WaitRequest),
        .o_ReadData         (o_ReadData),
        .o_ReadDataValid    (o_ReadDataValid)
    );

    for (genvar g = 0; g < SlaveCount; g++) begin : genMem
        burstMemory #(
            .MemDepthLog2 (MemDepthLog2),
            .WaitCycles   (WaitTable[g])
        ) uMem (
            .i_Clk           (i_Clk),
            .i_arstN         (i_arstN),
            .i_Addr          (slvAddr),
            .i_Read          (slvRead[g]),
            .i_Write         (slvWrite[g]),
            .i_BurstCount    (slvBurstCount),
            .i_WriteData     (slvWriteData),
            .o_WaitRequest   (slvWaitRequest[g]),
            .o_ReadData      (slvReadData[g]),
            .o_ReadDataValid (slvReadDataValid[g])
        );
    end

endmodule

`default_nettype wire

/* interconnect/slaveMux.sv */
`timescale 1ns/1ns
`default_nettype none

module slaveMux import avalonPkg::*, fabricPkg::*; (
    input  wire slaveMask_t i_SlaveReq,

    input  wire avAddr_t  i_Addr,
    input  wire           i_Read,
    input  wire           i_Write,
    input  wire avBurst_t i_BurstCount,
    input  wire avData_t  i_WriteData,

    output slaveMask_t o_SlvRead,
    output slaveMask_t o_SlvWrite,
    output avAddr_t    o_SlvAddr,
    output avBurst_t   o_SlvBurstCount,
    output avData_t    o_SlvWriteData,

    input  wire slaveMask_t i_SlvWaitRequest,
    input  wire avData_t    i_SlvReadData [SlaveCount],
    input  wire slaveMask_t i_SlvReadDataValid,

    output logic    o_WaitRequest,
    output avData_t o_ReadData,
    output logic    o_ReadDataValid
);

    logic cmdPresent;
    logic anyReq;

    assign cmdPresent = i_Read | i_Write;
    assign anyReq = |i_SlaveReq;

    // Strobes only reach the requested slave.
    assign o_SlvRead = {SlaveCount{i_Read}} & i_SlaveReq;
    assign o_SlvWrite = {SlaveCount{i_Write}} & i_SlaveReq;

    assign o_SlvAddr = i_Addr;
    assign o_SlvBurstCount = i_BurstCount;
    assign o_SlvWriteData = i_WriteData;

    // Stall a command that has no slave yet.
    assign o_WaitRequest = anyReq ? |(i_SlvWaitRequest & i_SlaveReq) : cmdPresent;
    assign o_ReadDataValid = |(i_SlvReadDataValid & i_SlaveReq);

    always_comb begin
        o_ReadData = '0;
        for (int i = 0; i < SlaveCount; i++) begin
            if (i_SlaveReq[i]) begin
                o_ReadData = i_SlvReadData[i];
            end
        end
    end

    // Valid must come from the slave the decoder still holds.
    always_comb begin
        ValidFromReq: assert #0 (
            $onehot0(i_SlvReadDataValid) && ((i_SlvReadDataValid & ~i_SlaveReq) == '0)
        ) else $error("Read data valid from several or unrequested slaves.");
    end

endmodule

`default_nettype wire

/* interconnect/inputDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inputDecoder import avalonPkg::*, fabricPkg::*; #(
    parameter int SelBits = 5,
    parameter int SlaveBase [SlaveCount] = '{0, 1, 2, 3, 4}
) (
    input  wire        i_Clk,
    input  wire        i_arstN,

    input  wire avAddr_t  i_Addr,
    input  wire           i_Read,
    input  wire           i_Write,
    input  wire avBurst_t i_BurstCount,
    input  wire           i_WaitRequest,
    input  wire           i_ReadDataValid,

    output slaveMask_t o_SlaveReq,
    output slaveMask_t o_NewTransaction
);

    logic [SelBits-1:0] upperBits;
    slaveSel_t decodeSel;
    slaveSel_t selQ;
    avBurst_t burstCnt;
    logic readQ;
    logic cmdPresent;
    logic idle;
    logic startCmd;
    logic writeBeat;
    logic beatDone;

    assign upperBits = i_Addr[AddrWidth-1 -: SelBits];
    assign cmdPresent = i_Read | i_Write;
    assign idle = (burstCnt == '0);
    assign startCmd = idle & cmdPresent;
    assign writeBeat = i_Write & ~i_WaitRequest;
    assign beatDone = readQ ? i_ReadDataValid : writeBeat;

    // Lowest matching index wins, no match falls back to slave 0.
    always_comb begin
        decodeSel = '0;
        for (int i = SlaveCount - 1; i >= 0; i--) begin
            if (upperBits == SelBits'(SlaveBase[i])) begin
                decodeSel = slaveSel_t'(i);
            end
        end
    end

    always_comb begin
        o_SlaveReq = '0;
        o_NewTransaction = '0;
        if (!idle) begin
            o_SlaveReq[selQ] = 1'b1; // Held for the rest of the burst.
        end else if (cmdPresent) begin
            o_SlaveReq[decodeSel] = 1'b1;
            o_NewTransaction[decodeSel] = 1'b1;
        end
    end

    // A zero-wait write may hand over its first beat in the start cycle.
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            burstCnt <= '0;
            selQ <= '0;
            readQ <= 1'b0;
        end else if (startCmd) begin
            burstCnt <= i_BurstCount - avBurst_t'(writeBeat);
            selQ <= decodeSel;
            readQ <= i_Read;
        end else if (!idle && beatDone) begin
            burstCnt <= burstCnt - 1'b1;
        end
    end

    ReqOneHot: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        $onehot0(o_SlaveReq) && ((o_NewTransaction & ~o_SlaveReq) == '0)
    ) else $error("Slave request is not one-hot.");

    // Burst length is checked against the returned beats downstream.
    NoEmptyBurst: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        startCmd |-> (i_BurstCount != '0)
    ) else $error("Command started with a zero burst count.");

endmodule

`default_nettype wire

/* logic/burstMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module burstMemory import avalonPkg::*, fabricPkg::*; #(
    parameter int MemDepthLog2 = 6,
    parameter int WaitCycles = 0
) (
    input  wire           i_Clk,
    input  wire           i_arstN,

    input  wire avAddr_t  i_Addr,
    input  wire           i_Read,
    input  wire           i_Write,
    input  wire avBurst_t i_BurstCount,
    input  wire avData_t  i_WriteData,

    output logic    o_WaitRequest,
    output avData_t o_ReadData,
    output logic    o_ReadDataValid
);

    localparam int CntBits = $clog2(WaitCycles + 2);

    typedef logic [MemDepthLog2-1:0] memAddr_t;

    avData_t mem [2**MemDepthLog2];
    memState_e state;
    logic [CntBits-1:0] waitCnt;
    avBurst_t beatsLeft;
    memAddr_t addrQ;
    memAddr_t beatAddr;
    logic ready;
    logic startWr;
    logic startRd;
    logic burstWr;
    logic nextRd;

    // First beat takes the bus address, later beats the running one.
    assign beatAddr = (state == Idle || state == Wait) ? i_Addr[MemDepthLog2-1:0] : addrQ;
    assign ready = ((state == Idle) && (WaitCycles == 0)) || ((state == Wait) && (waitCnt == '0));
    assign startWr = ready & i_Write;
    assign startRd = ready & i_Read & ~i_Write;
    assign burstWr = (state == WriteBurst) & i_Write;
    assign nextRd = (state == ReadBurst) && (beatsLeft != avBurst_t'(1));

    always_comb begin
        case (state)
            Idle:       o_WaitRequest = (i_Read | i_Write) && (WaitCycles != 0);
            Wait:       o_WaitRequest = (waitCnt != '0);
            WriteBurst: o_WaitRequest = 1'b0;
            default:    o_WaitRequest = 1'b1; // No new command during a read burst.
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state <= Idle;
            waitCnt <= '0;
            beatsLeft <= '0;
            o_ReadDataValid <= 1'b0;
        end else if (startWr) begin
            beatsLeft <= i_BurstCount - 1'b1;
            state <= (i_BurstCount == avBurst_t'(1)) ? Idle : WriteBurst;
        end else if (startRd) begin
            beatsLeft <= i_BurstCount;
            o_ReadDataValid <= 1'b1;
            state <= ReadBurst;
        end else begin
            case (state)
                Idle: begin
                    if (i_Read || i_Write) begin
                        state <= Wait;
                        waitCnt <= CntBits'(WaitCycles - 1);
                    end
                end
                Wait: begin
                    if (waitCnt != '0) begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                WriteBurst: begin
                    if (i_Write) begin
                        beatsLeft <= beatsLeft - 1'b1;
                        if (beatsLeft == avBurst_t'(1)) begin
                            state <= Idle;
                        end
                    end
                end
                default: begin
                    if (nextRd) begin
                        beatsLeft <= beatsLeft - 1'b1;
                    end else begin
                        o_ReadDataValid <= 1'b0; // Last beat is on the bus.
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_Clk) begin
        if (startWr || burstWr) begin
            mem[beatAddr] <= i_WriteData;
        end
        if (startRd || nextRd) begin
            o_ReadData <= mem[beatAddr];
        end
        if (startWr || burstWr || startRd || nextRd) begin
            addrQ <= beatAddr + 1'b1;
        end
    end

    ValidInRead: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        o_ReadDataValid |-> (state == ReadBurst)
    ) else $error("Read data valid outside a read burst, state %s.", state.name());

endmodule

`default_nettype wire

/* common/fabricPkg.sv */
`default_nettype none

// Fabric topology and slave-side state definitions.
package fabricPkg;

    localparam int SlaveCount = 5;
    localparam int SelWidth = $clog2(SlaveCount);

    typedef logic [SelWidth-1:0] slaveSel_t;

    // One bit per slave port, one-hot or empty.
    typedef logic [SlaveCount-1:0] slaveMask_t;

    typedef enum logic [1:0] {
        Idle,
        Wait,       // Counting wait states before the first beat.
        WriteBurst,
        ReadBurst
    } memState_e;

endpackage

`default_nettype wire

/* common/avalonPkg.sv */
`default_nettype none

// Avalon-MM bus widths and field types shared by master and slave sides.
package avalonPkg;

    // Word address, not byte address.
    localparam int AddrWidth = 30;
    localparam int DataWidth = 32;
    localparam int BurstWidth = 8;

    typedef logic [AddrWidth-1:0] avAddr_t;
    typedef logic [DataWidth-1:0] avData_t;

    // Number of beats; zero is not a legal burst.
    typedef logic [BurstWidth-1:0] avBurst_t;

endpackage

`default_nettype wire
